//--- verilog.f
+incdir+.
mm_pkg.sv
instr_slot.sv
job_control.sv
a_strip_issuer.sv
b_strip_issuer.sv
c_tile_issuer.sv
matrix_controller.sv
tb_matrix_controller.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass message
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_matrix_controller -f verilog.f -o sim_tb
output=$(./obj_dir/sim_tb 2>&1 || true)
echo "$output"
if grep -q "ALL TESTS PASSED" <<< "$output"; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

//--- tb_matrix_controller.sv
// Testbench for the matrix-multiply instruction controller
// Runs a job with L = 8, then one with L = 16 and other base addresses
// Readys and completion reports are random, from a fixed-seed LFSR
// A writer only reports a tile it has already received
`timescale 1ns/1ps
`include "mm_cfg.svh"

module tb_matrix_controller;

  localparam int n       = `MM_TILE_N;
  localparam int rows    = `MM_ROWS;
  localparam int cols    = `MM_COLS;
  localparam int writers = `MM_WRITERS;

  // Two short jobs, each given at most 25000 cycles of 4 ns
  localparam int timeout_ns = 2 * 25_000 * 4;

  logic                 clk;
  logic                 reset;
  mm_pkg::addr_t        a_base;
  mm_pkg::addr_t        b_base;
  mm_pkg::addr_t        c_base;
  mm_pkg::len_t         matrix_length;
  logic                 job_valid;
  logic                 job_ready;
  logic                 done;
  logic [rows-1:0]      a_valid;
  logic [rows-1:0]      a_ready;
  mm_pkg::strip_instr_t a_instr [rows];
  logic [cols-1:0]      b_valid;
  logic [cols-1:0]      b_ready;
  mm_pkg::strip_instr_t b_instr [cols];
  logic [writers-1:0]   c_valid;
  logic [writers-1:0]   c_ready;
  mm_pkg::tile_instr_t  c_instr [writers];
  logic [writers-1:0]   done_valid;
  logic [writers-1:0]   done_ready;

  // Reference model state for the current job and the transfers seen per lane
  mm_pkg::addr_t job_a;
  mm_pkg::addr_t job_b;
  mm_pkg::addr_t job_c;
  int            job_len = 0;
  int            a_cnt [rows];
  int            b_cnt [cols];
  int            c_cnt [writers];
  int            sent [writers];
  logic          model_busy;
  logic          model_done;
  logic          accept;
  logic [31:0]   lfsr = 32'h1c59_1bef;

  matrix_controller DUT (.*);

  // Instructions per lane and owed reports per writer
  function automatic int a_count();
    return job_len / (n * rows);
  endfunction

  function automatic int b_count();
    return (job_len / (n * rows)) * (job_len / (n * cols));
  endfunction

  function automatic int c_count();
    return (job_len / n) * (job_len / n) / writers;
  endfunction

  // A lane r, instruction k reads row strip k*ROWS + r
  function automatic logic [63:0] exp_a(int r, int k);
    mm_pkg::strip_instr_t s;
    s.address = job_a + mm_pkg::addr_t'((k * rows + r) * n * job_len);
    s.length  = mm_pkg::len_t'(job_len);
    s.repeats = mm_pkg::count_t'(job_len / (n * cols));
    return 64'(s);
  endfunction

  // B lane c sweeps its column strips again for every A strip
  function automatic logic [63:0] exp_b(int c, int k);
    mm_pkg::strip_instr_t s;
    int                   j;
    j = (k % (job_len / (n * cols))) * cols + c;
    s.address = job_b + mm_pkg::addr_t'(j * n * job_len);
    s.length  = mm_pkg::len_t'(job_len);
    s.repeats = mm_pkg::count_t'(1);
    return 64'(s);
  endfunction

  // Tiles of N*N elements dealt round robin over the writers
  function automatic logic [63:0] exp_c(int w, int k);
    return 64'(job_c + mm_pkg::addr_t'((k * writers + w) * n * n));
  endfunction

  function automatic logic reports_done();
    for (int w = 0; w < writers; w++) begin
      if (sent[w] != c_count()) return 1'b0;
    end
    return 1'b1;
  endfunction

  // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic draw_bit();
    lfsr = lfsr_step(lfsr);
    return lfsr[0];
  endfunction

  task automatic report_error(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
    $display("[ERROR] %0d ns %s expected %0h actual %0h", $time, name, expected, actual);
    $display("SOME TESTS FAILED");
    $fatal(1, "Stopping at the first error");
  endtask

  task automatic check_count(input string name, input int expected, input int actual);
    assert (actual == expected)
      else report_error(name, 64'(expected), 64'(actual));
  endtask

  // Outputs of an idle controller right after reset
  task automatic expect_idle();
    assert (job_ready)
      else report_error("job_ready", 64'd1, 64'(job_ready));
    assert (!done)
      else report_error("done", 64'd0, 64'(done));
    assert (a_valid == '0)
      else report_error("a_valid", 64'd0, 64'(a_valid));
    assert (b_valid == '0)
      else report_error("b_valid", 64'd0, 64'(b_valid));
    assert (c_valid == '0)
      else report_error("c_valid", 64'd0, 64'(c_valid));
    assert (done_ready == '0)
      else report_error("done_ready", 64'd0, 64'(done_ready));
  endtask

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    #timeout_ns;
    $display("Timeout: the jobs did not finish within %0d ns", timeout_ns);
    $display("SOME TESTS FAILED");
    $fatal(1, "Watchdog expired");
  end

  // Random back-pressure on every lane and random completion reports
  initial begin
    a_ready    = '0;
    b_ready    = '0;
    c_ready    = '0;
    done_valid = '0;
    forever begin
      @(posedge clk);
      #1;
      for (int r = 0; r < rows; r++) a_ready[r] = draw_bit();
      for (int c = 0; c < cols; c++) b_ready[c] = draw_bit();
      for (int w = 0; w < writers; w++) c_ready[w] = draw_bit();
      for (int w = 0; w < writers; w++) done_valid[w] = draw_bit() && (c_cnt[w] > sent[w]);
    end
  end

  assign accept = job_valid && job_ready;

  // Busy from acceptance until one cycle after the last owed report
  always @(posedge clk) begin
    if (reset) begin
      model_busy <= 1'b0;
      model_done <= 1'b0;
    end else if (accept) begin
      model_busy <= 1'b1;
      model_done <= 1'b0;
    end else if (model_busy && reports_done()) begin
      model_busy <= 1'b0;
      model_done <= 1'b1;
    end
    for (int r = 0; r < rows; r++)
      a_cnt[r] <= (reset || accept) ? 0 : a_cnt[r] + int'(a_valid[r] && a_ready[r]);
    for (int c = 0; c < cols; c++)
      b_cnt[c] <= (reset || accept) ? 0 : b_cnt[c] + int'(b_valid[c] && b_ready[c]);
    for (int w = 0; w < writers; w++) begin
      c_cnt[w] <= (reset || accept) ? 0 : c_cnt[w] + int'(c_valid[w] && c_ready[w]);
      sent[w]  <= (reset || accept) ? 0 : sent[w] + int'(done_valid[w] && done_ready[w]);
    end
  end

  // Also covers the idle state right after reset
  assert property (@(posedge clk) disable iff (reset) job_ready == !model_busy)
    else report_error("job_ready", 64'(!$sampled(model_busy)), 64'($sampled(job_ready)));
  assert property (@(posedge clk) disable iff (reset) done == model_done)
    else report_error("done", 64'($sampled(model_done)), 64'($sampled(done)));

  // Payload must match instruction cnt whenever valid is high
  // cnt only moves on a transfer, so a stalled payload must hold
  for (genvar r = 0; r < rows; r++) begin : g_a
    assert property (@(posedge clk) disable iff (reset) !a_valid[r] || a_cnt[r] < a_count())
      else report_error($sformatf("a_valid[%0d]", r), 64'd0, 64'd1);
    assert property (@(posedge clk) disable iff (reset)
      !a_valid[r] || 64'(a_instr[r]) == exp_a(r, a_cnt[r]))
      else report_error($sformatf("a_instr[%0d]", r), exp_a(r, $sampled(a_cnt[r])),
                        64'($sampled(a_instr[r])));
  end

  for (genvar c = 0; c < cols; c++) begin : g_b
    assert property (@(posedge clk) disable iff (reset) !b_valid[c] || b_cnt[c] < b_count())
      else report_error($sformatf("b_valid[%0d]", c), 64'd0, 64'd1);
    assert property (@(posedge clk) disable iff (reset)
      !b_valid[c] || 64'(b_instr[c]) == exp_b(c, b_cnt[c]))
      else report_error($sformatf("b_instr[%0d]", c), exp_b(c, $sampled(b_cnt[c])),
                        64'($sampled(b_instr[c])));
  end

  for (genvar w = 0; w < writers; w++) begin : g_c
    assert property (@(posedge clk) disable iff (reset) !c_valid[w] || c_cnt[w] < c_count())
      else report_error($sformatf("c_valid[%0d]", w), 64'd0, 64'd1);
    assert property (@(posedge clk) disable iff (reset)
      !c_valid[w] || 64'(c_instr[w]) == exp_c(w, c_cnt[w]))
      else report_error($sformatf("c_instr[%0d]", w), exp_c(w, $sampled(c_cnt[w])),
                        64'($sampled(c_instr[w])));
    // Writer takes reports exactly while busy and still owing some
    assert property (@(posedge clk) disable iff (reset)
      done_ready[w] == (model_busy && sent[w] < c_count()))
      else report_error($sformatf("done_ready[%0d]", w),
                        64'($sampled(model_busy) && $sampled(sent[w]) < c_count()),
                        64'($sampled(done_ready[w])));
  end

  // Runs one job while other values stay offered and must be ignored
  task automatic run_job(input mm_pkg::addr_t a, input mm_pkg::addr_t b,
                         input mm_pkg::addr_t c, input int len);
    job_a = a;
    job_b = b;
    job_c = c;
    job_len = len;
    a_base = a;
    b_base = b;
    c_base = c;
    matrix_length = mm_pkg::len_t'(len);
    job_valid = 1'b1;
    @(posedge clk);
    #1;
    a_base = ~a;
    b_base = ~b;
    c_base = ~c;
    matrix_length = mm_pkg::len_t'(2 * len);
    while (!done) begin
      @(posedge clk);
      #1;
    end
    job_valid = 1'b0;
    // A and B lanes may still drain after done
    while (a_valid != '0 || b_valid != '0 || c_valid != '0) begin
      @(posedge clk);
      #1;
    end
    for (int r = 0; r < rows; r++) check_count($sformatf("a_valid[%0d] transfers", r),
                                               a_count(), a_cnt[r]);
    for (int k = 0; k < cols; k++) check_count($sformatf("b_valid[%0d] transfers", k),
                                               b_count(), b_cnt[k]);
  endtask

  initial begin
    reset = 1'b1;
    job_valid = 1'b0;
    a_base = '0;
    b_base = '0;
    c_base = '0;
    matrix_length = '0;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;
    expect_idle();
    run_job(32'h1000_0000, 32'h2000_0000, 32'h3000_0000, 8);
    run_job(32'h4000_0400, 32'h5000_0800, 32'h6000_0c00, 16);
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

//--- matrix_controller.sv
// Instruction controller of the tiled matrix-multiply engine
// Matrix length must be a power of two, a multiple of 8, at most 256
// No checking is done on the job inputs
// First instructions appear two cycles after the accepting edge
// done rises one cycle after the last completion report is taken
`timescale 1ns/1ps
`include "mm_cfg.svh"

module matrix_controller (
  input  logic                   clk,
  input  logic                   reset,

  // Job handshake
  input  mm_pkg::addr_t          a_base,
  input  mm_pkg::addr_t          b_base,
  input  mm_pkg::addr_t          c_base,
  input  mm_pkg::len_t           matrix_length,
  input  logic                   job_valid,
  output logic                   job_ready,
  output logic                   done,

  // A buffer lanes
  output logic [`MM_ROWS-1:0]    a_valid,
  input  logic [`MM_ROWS-1:0]    a_ready,
  output mm_pkg::strip_instr_t   a_instr [`MM_ROWS],

  // B buffer lanes
  output logic [`MM_COLS-1:0]    b_valid,
  input  logic [`MM_COLS-1:0]    b_ready,
  output mm_pkg::strip_instr_t   b_instr [`MM_COLS],

  // Output writer lanes
  output logic [`MM_WRITERS-1:0] c_valid,
  input  logic [`MM_WRITERS-1:0] c_ready,
  output mm_pkg::tile_instr_t    c_instr [`MM_WRITERS],

  // Completion reports from the writers
  input  logic [`MM_WRITERS-1:0] done_valid,
  output logic [`MM_WRITERS-1:0] done_ready
);

  // Registered job, shared by all issuers
  mm_pkg::addr_t a_base_q;
  mm_pkg::addr_t b_base_q;
  mm_pkg::addr_t c_base_q;
  mm_pkg::len_t  length_q;
  logic          start;

  job_control u_job_control (
    .clk           (clk),
    .reset         (reset),
    .a_base_in     (a_base),
    .b_base_in     (b_base),
    .c_base_in     (c_base),
    .matrix_length (matrix_length),
    .job_valid     (job_valid),
    .job_ready     (job_ready),
    .a_base        (a_base_q),
    .b_base        (b_base_q),
    .c_base        (c_base_q),
    .length        (length_q),
    .start         (start),
    .done_valid    (done_valid),
    .done_ready    (done_ready),
    .done          (done)
  );

  a_strip_issuer u_a_strip_issuer (
    .clk     (clk),
    .reset   (reset),
    .start   (start),
    .a_base  (a_base_q),
    .length  (length_q),
    .a_valid (a_valid),
    .a_ready (a_ready),
    .a_instr (a_instr)
  );

  b_strip_issuer u_b_strip_issuer (
    .clk     (clk),
    .reset   (reset),
    .start   (start),
    .b_base  (b_base_q),
    .length  (length_q),
    .b_valid (b_valid),
    .b_ready (b_ready),
    .b_instr (b_instr)
  );

  c_tile_issuer u_c_tile_issuer (
    .clk     (clk),
    .reset   (reset),
    .start   (start),
    .c_base  (c_base_q),
    .length  (length_q),
    .c_valid (c_valid),
    .c_ready (c_ready),
    .c_instr (c_instr)
  );

endmodule

//--- c_tile_issuer.sv
// Tile instructions for the output writers, one lane per writer
// Writer w gets tiles w, w+WRITERS, w+2*WRITERS and so on
// Each tile is N*N elements, laid out back to back in C
`timescale 1ns/1ps
`include "mm_cfg.svh"

module c_tile_issuer (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   start,
  input  mm_pkg::addr_t          c_base,
  input  mm_pkg::len_t           length,
  output logic [`MM_WRITERS-1:0] c_valid,
  input  logic [`MM_WRITERS-1:0] c_ready,
  output mm_pkg::tile_instr_t    c_instr [`MM_WRITERS]
);

  localparam int n_shift      = $clog2(`MM_TILE_N);
  localparam int tile_shift   = $clog2(`MM_TILE_N * `MM_TILE_N);
  localparam int writer_shift = $clog2(`MM_WRITERS);

  mm_pkg::count_t side_tiles;
  mm_pkg::count_t lane_count;

  // (L/N)^2 tiles shared evenly over the writers
  assign side_tiles = mm_pkg::count_t'(length) >> n_shift;
  assign lane_count = (side_tiles * side_tiles) >> writer_shift;

  for (genvar w = 0; w < `MM_WRITERS; w++) begin : g_lane
    mm_pkg::count_t      index;
    mm_pkg::addr_t       tile;
    mm_pkg::tile_instr_t next_instr;

    // Global tile number for instruction index of this writer
    assign tile = mm_pkg::addr_t'(index) * `MM_WRITERS + w;

    assign next_instr = '{address: c_base + (tile << tile_shift)};

    instr_slot #(
      .payload_t (mm_pkg::tile_instr_t)
    ) u_slot (
      .clk          (clk),
      .reset        (reset),
      .start        (start),
      .count        (lane_count),
      .next_payload (next_instr),
      .index        (index),
      .valid        (c_valid[w]),
      .ready        (c_ready[w]),
      .payload      (c_instr[w])
    );
  end

endmodule

//--- b_strip_issuer.sv
// Strip instructions for the B input buffers, one lane per processor column
// Column strips are handed out again for every A strip
// Lane c cycles through strips c, c+COLS, ... then wraps
// Matrix length must be a power of two and a multiple of 8
`timescale 1ns/1ps
`include "mm_cfg.svh"

module b_strip_issuer (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 start,
  input  mm_pkg::addr_t        b_base,
  input  mm_pkg::len_t         length,
  output logic [`MM_COLS-1:0]  b_valid,
  input  logic [`MM_COLS-1:0]  b_ready,
  output mm_pkg::strip_instr_t b_instr [`MM_COLS]
);

  localparam int row_shift = $clog2(`MM_TILE_N * `MM_ROWS);
  localparam int col_shift = $clog2(`MM_TILE_N * `MM_COLS);
  localparam int n_shift   = $clog2(`MM_TILE_N);

  mm_pkg::count_t a_strips;
  mm_pkg::count_t b_strips;
  mm_pkg::count_t lane_count;
  mm_pkg::count_t wrap_mask;
  mm_pkg::addr_t  stride;

  // A strips per A lane and B strips per B lane
  assign a_strips = mm_pkg::count_t'(length) >> row_shift;
  assign b_strips = mm_pkg::count_t'(length) >> col_shift;

  // Full B sweep repeated for each A strip
  assign lane_count = a_strips * b_strips;

  // b_strips is a power of two, so the wrap is a mask
  assign wrap_mask = b_strips - 1'b1;

  // One strip spans N columns of L elements
  assign stride = mm_pkg::addr_t'(length) << n_shift;

  for (genvar c = 0; c < `MM_COLS; c++) begin : g_lane
    mm_pkg::count_t       index;
    mm_pkg::addr_t        strip;
    mm_pkg::strip_instr_t next_instr;

    // Position inside the current sweep, then global strip number
    assign strip = mm_pkg::addr_t'(index & wrap_mask) * `MM_COLS + c;

    // Each B strip is streamed once per instruction
    assign next_instr = '{
      address: b_base + strip * stride,
      length:  length,
      repeats: mm_pkg::count_t'(1)
    };

    instr_slot #(
      .payload_t (mm_pkg::strip_instr_t)
    ) u_slot (
      .clk          (clk),
      .reset        (reset),
      .start        (start),
      .count        (lane_count),
      .next_payload (next_instr),
      .index        (index),
      .valid        (b_valid[c]),
      .ready        (b_ready[c]),
      .payload      (b_instr[c])
    );
  end

endmodule

//--- a_strip_issuer.sv
// Strip instructions for the A input buffers, one lane per processor row
// Lane r gets row strips r, r+ROWS, r+2*ROWS and so on
// Each strip is replayed once per column tile a B lane covers
// Matrix length must be a power of two and a multiple of 8
`timescale 1ns/1ps
`include "mm_cfg.svh"

module a_strip_issuer (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 start,
  input  mm_pkg::addr_t        a_base,
  input  mm_pkg::len_t         length,
  output logic [`MM_ROWS-1:0]  a_valid,
  input  logic [`MM_ROWS-1:0]  a_ready,
  output mm_pkg::strip_instr_t a_instr [`MM_ROWS]
);

  localparam int row_shift = $clog2(`MM_TILE_N * `MM_ROWS);
  localparam int col_shift = $clog2(`MM_TILE_N * `MM_COLS);
  localparam int n_shift   = $clog2(`MM_TILE_N);

  mm_pkg::count_t lane_count;
  mm_pkg::count_t repeats;
  mm_pkg::addr_t  stride;

  // Strips per lane, L / (N*ROWS)
  assign lane_count = mm_pkg::count_t'(length) >> row_shift;

  // Replays per strip, L / (N*COLS)
  assign repeats = mm_pkg::count_t'(length) >> col_shift;

  // One strip spans N rows of L elements
  assign stride = mm_pkg::addr_t'(length) << n_shift;

  for (genvar r = 0; r < `MM_ROWS; r++) begin : g_lane
    mm_pkg::count_t       index;
    mm_pkg::addr_t        strip;
    mm_pkg::strip_instr_t next_instr;

    // Global strip number for instruction index of this lane
    assign strip = mm_pkg::addr_t'(index) * `MM_ROWS + r;

    assign next_instr = '{address: a_base + strip * stride, length: length, repeats: repeats};

    instr_slot #(
      .payload_t (mm_pkg::strip_instr_t)
    ) u_slot (
      .clk          (clk),
      .reset        (reset),
      .start        (start),
      .count        (lane_count),
      .next_payload (next_instr),
      .index        (index),
      .valid        (a_valid[r]),
      .ready        (a_ready[r]),
      .payload      (a_instr[r])
    );
  end

endmodule

//--- job_control.sv
// Job handshake, job registers and completion tracking
// Base addresses and length are sampled on the accepting edge
// start pulses in the cycle after acceptance
// Each writer owes (L/N)^2 / MM_WRITERS completion reports per job
`timescale 1ns/1ps
`include "mm_cfg.svh"

module job_control (
  input  logic                    clk,
  input  logic                    reset,
  input  mm_pkg::addr_t           a_base_in,
  input  mm_pkg::addr_t           b_base_in,
  input  mm_pkg::addr_t           c_base_in,
  input  mm_pkg::len_t            matrix_length,
  input  logic                    job_valid,
  output logic                    job_ready,
  output mm_pkg::addr_t           a_base,
  output mm_pkg::addr_t           b_base,
  output mm_pkg::addr_t           c_base,
  output mm_pkg::len_t            length,
  output logic                    start,
  input  logic [`MM_WRITERS-1:0]  done_valid,
  output logic [`MM_WRITERS-1:0]  done_ready,
  output logic                    done
);

  localparam int tile_shift   = $clog2(`MM_TILE_N);
  localparam int writer_shift = $clog2(`MM_WRITERS);

  logic           busy;
  logic           accept;
  logic           all_reported;
  mm_pkg::count_t side_tiles;
  mm_pkg::count_t owed_load;
  mm_pkg::count_t owed [`MM_WRITERS];

  assign job_ready = !busy;
  assign accept    = job_valid && job_ready;

  // Tiles along one edge, then the share of all tiles per writer
  assign side_tiles = mm_pkg::count_t'(matrix_length) >> tile_shift;
  assign owed_load  = (side_tiles * side_tiles) >> writer_shift;

  // Busy flag, done level and start pulse
  always_ff @(posedge clk) begin
    if (reset) begin
      busy  <= 1'b0;
      done  <= 1'b0;
      start <= 1'b0;
    end else begin
      start <= accept;
      if (accept) begin
        busy <= 1'b1;
        done <= 1'b0;
      end else if (busy && all_reported) begin
        busy <= 1'b0;
        done <= 1'b1;
      end
    end
  end

  // Job registers, held for the whole job
  always_ff @(posedge clk) begin
    if (accept) begin
      a_base <= a_base_in;
      b_base <= b_base_in;
      c_base <= c_base_in;
      length <= matrix_length;
    end
  end

  // Per-writer owed reports
  // Loaded on acceptance so nothing looks finished in the start cycle
  always_ff @(posedge clk) begin
    for (int w = 0; w < `MM_WRITERS; w++) begin
      if (reset) begin
        owed[w] <= '0;
      end else if (accept) begin
        owed[w] <= owed_load;
      end else if (done_valid[w] && done_ready[w]) begin
        owed[w] <= owed[w] - 1'b1;
      end
    end
  end

  // A writer is only ready for reports it still owes
  always_comb begin
    for (int w = 0; w < `MM_WRITERS; w++) begin
      done_ready[w] = busy && (owed[w] != '0);
    end
  end

  always_comb begin
    all_reported = 1'b1;
    for (int w = 0; w < `MM_WRITERS; w++) begin
      if (owed[w] != '0) begin
        all_reported = 1'b0;
      end
    end
  end

endmodule

//--- instr_slot.sv
// One valid/ready instruction lane with its own countdown
// Issuer computes next_payload combinationally from index
// start must only arrive while the lane is idle
// Payload for index k is registered on start or on the transfer of k-1
`timescale 1ns/1ps

module instr_slot #(
  parameter type payload_t = logic [31:0]
) (
  input  logic           clk,
  input  logic           reset,
  input  logic           start,
  input  mm_pkg::count_t count,
  input  payload_t       next_payload,
  output mm_pkg::count_t index,
  output logic           valid,
  input  logic           ready,
  output payload_t       payload
);

  // Instructions still to hand over, including the one on payload
  mm_pkg::count_t remaining;

  // Index of the instruction that follows the one on payload
  mm_pkg::count_t next_index;

  logic transfer;

  assign transfer = valid && ready;

  // Lane stays valid until the countdown runs out
  assign valid = (remaining != '0);

  // During start the issuer must build instruction 0
  assign index = start ? '0 : next_index;

  always_ff @(posedge clk) begin
    if (reset) begin
      remaining  <= '0;
      next_index <= '0;
    end else if (start) begin
      remaining  <= count;
      next_index <= mm_pkg::count_t'(1);
    end else if (transfer) begin
      remaining  <= remaining - 1'b1;
      next_index <= next_index + 1'b1;
    end
  end

  // Payload only moves on start or transfer, so it holds under back-pressure
  // After the last transfer it picks up an unused value while valid is low
  always_ff @(posedge clk) begin
    if (start || transfer) begin
      payload <= next_payload;
    end
  end

endmodule

//--- mm_pkg.sv
// Shared types of the matrix-multiply instruction controller
// Field widths follow the sizes in the config header
// Strip instructions go to A and B buffers, tile instructions to output writers

`include "mm_cfg.svh"

package mm_pkg;

  // Byte address into the shared memory
  typedef logic [`MM_ADDR_BITS-1:0] addr_t;

  // Matrix length, 0 to MM_MAX_LEN
  typedef logic [`MM_LEN_BITS-1:0] len_t;

  // Instruction and report counters
  typedef logic [`MM_COUNT_BITS-1:0] count_t;

  // Strip instruction for an input buffer
  // address is the first element of the strip
  // length is the strip length in elements
  // repeats is how many times the buffer replays the strip
  typedef struct packed {
    addr_t  address;
    len_t   length;
    count_t repeats;
  } strip_instr_t;

  // Tile instruction for an output writer
  // Only the tile base address in C is needed
  typedef struct packed {
    addr_t address;
  } tile_instr_t;

endpackage

//--- mm_cfg.svh
// Build-time sizes of the matrix-multiply instruction controller
// Tile edge and processor grid sizes must be powers of two
// MM_WRITERS must stay equal to MM_ROWS * MM_COLS
// Matrix length is limited to MM_MAX_LEN and sized by MM_LEN_BITS
`ifndef MM_CFG_SVH
`define MM_CFG_SVH

// Edge of one square tile handled by a processor
`define MM_TILE_N 4

// Processor grid, one A buffer per row and one B buffer per column
`define MM_ROWS 2
`define MM_COLS 2

// One output writer per processor
`define MM_WRITERS (`MM_ROWS * `MM_COLS)

// Memory address width
`define MM_ADDR_BITS 32

// Largest supported matrix length and the bits to hold it
`define MM_MAX_LEN 256
`define MM_LEN_BITS ($clog2(`MM_MAX_LEN + 1))

// Wide enough for any per-lane instruction or report count
`define MM_COUNT_BITS 13

`endif
